// File: Makefile
# Verilator build and run for the ingress policer testbench

VERILATOR ?= verilator
TOP       ?= policer_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard logic/*.sv) $(wildcard dv/*.sv) $(wildcard dv/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Status comes from the pass line in the simulator output
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '\*\* PASS \*\*'

clean:
	rm -rf $(OBJ_DIR)

// File: dv/policer_model.svh
/* Reference model, random source and expected queues for the policer testbench.
   Included inside the testbench module after its counters and enables. */

`ifndef POLICER_MODEL_SVH
`define POLICER_MODEL_SVH

localparam int meta_w = 2 * policer_pkg::port_w + policer_pkg::prio_w + policer_pkg::byte_len_w;

// 16-bit Galois LFSR, taps 16 14 13 11
logic [15:0] lfsr_state = 16'd62;

// Whole-byte levels, exact while CIR stays at zero
int unsigned                   bucket_level [policer_pkg::num_ports];
logic [policer_pkg::cbs_w-1:0] bucket_cbs   [policer_pkg::num_ports];

// One entry per beat, and one per packet for metadata and mark
logic [policer_pkg::data_w-1:0] exp_data [$];
logic                           exp_last [$];
logic [meta_w-1:0]              exp_meta [$];
logic                           exp_mark [$];

function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    if (s[0]) begin
        return (s >> 1) ^ 16'hB400;
    end
    return s >> 1;
endfunction

// One LFSR step per bit taken
function automatic int unsigned take_bits(input int n);
    int unsigned v;
    v = 0;
    for (int i = 0; i < n; i++) begin
        v          = (v << 1) | lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
endfunction

function automatic void clear_model();
    for (int p = 0; p < policer_pkg::num_ports; p++) begin
        bucket_level[p] = 0;
        bucket_cbs[p]   = '0;
    end
endfunction

// Bucket rule with no drain; a marked or disabled packet is not charged
function automatic logic police(input int port, input int len);
    logic drop;
    drop = enable[port] && (bucket_level[port] + len > bucket_cbs[port]);
    if (enable[port] && !drop) begin
        bucket_level[port] += len;
    end
    return drop;
endfunction

function automatic void report_mismatch(input string field, input longint unsigned expected,
                                        input longint unsigned actual);
    value_errors++;
    $display("[FAIL] %s %s: expected %0h, actual %0h", test_name, field, expected, actual);
endfunction

`endif

// File: dv/policer_tb.sv
/* Testbench for the ingress policer top level. Runs six stimulus phases and
   checks every output beat against the model queues. */

`timescale 1ns/1ps

module policer_tb;

    localparam int     clk_period  = 40;
    localparam int     max_beats   = (1500 + policer_pkg::data_bytes - 1) / policer_pkg::data_bytes;
    localparam int     total_pkts  = 151;
    localparam int     cir_min     = 128;
    localparam longint cir_wait    = policer_pkg::num_ports * (256000 / cir_min + 16);
    localparam longint watchdog_ns = (longint'(total_pkts) * max_beats * 4 + cir_wait) * clk_period;

    logic                                core_clk_ifc;
    logic                                timer_reset;
    logic [policer_pkg::num_ports-1:0]   enable;
    logic                                cfg_valid;
    logic [policer_pkg::cfg_addr_w-1:0]  cfg_addr;
    logic [policer_pkg::cfg_data_w-1:0]  cfg_data;
    logic                                in_valid;
    logic                                in_ready;
    logic [policer_pkg::data_w-1:0]      in_data;
    logic                                in_last;
    logic [policer_pkg::port_w-1:0]      in_ingress_port;
    logic [policer_pkg::port_w-1:0]      in_egress_port;
    logic [policer_pkg::prio_w-1:0]      in_prio;
    logic [policer_pkg::byte_len_w-1:0]  in_byte_length;
    logic                                out_valid;
    logic                                out_ready;
    logic [policer_pkg::data_w-1:0]      out_data;
    logic                                out_last;
    logic [policer_pkg::port_w-1:0]      out_ingress_port;
    logic [policer_pkg::port_w-1:0]      out_egress_port;
    logic [policer_pkg::prio_w-1:0]      out_prio;
    logic [policer_pkg::byte_len_w-1:0]  out_byte_length;
    logic                                out_drop_mark;

    int          value_errors = 0;
    int          protocol_errors = 0;
    string       test_name = "idle";
    longint      cycle_cnt = 0;
    logic        gaps_on = 1'b0;
    logic [15:0] gap_lfsr = 16'd62;

    `include "policer_model.svh"

    policer_top DUT (.*);

    always #(clk_period / 2) core_clk_ifc = ~core_clk_ifc;

    always @(posedge core_clk_ifc) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // Random sink stalls in the gap phase
    always @(negedge core_clk_ifc) begin
        if (gaps_on) begin
            out_ready <= gap_lfsr[0];
            gap_lfsr  <= lfsr_next(gap_lfsr);
        end else begin
            out_ready <= 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Output checks
    //////////////////////////////////////////////////

    assert property (@(posedge core_clk_ifc) disable iff (timer_reset)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data) && $stable(out_last)
            && $stable(out_drop_mark)
            && $stable({out_ingress_port, out_egress_port, out_prio, out_byte_length})))
    else begin
        protocol_errors++;
        $display("Output beat changed or vanished while the sink was stalling");
    end

    always @(posedge core_clk_ifc) begin
        if (!timer_reset && out_valid && out_ready) begin
            if (exp_data.size() == 0) begin
                protocol_errors++;
                $display("Output beat appeared with no packet outstanding in %s", test_name);
            end else begin
                assert (out_data == exp_data[0]) else report_mismatch("data", exp_data[0], out_data);
                assert (out_last == exp_last[0]) else report_mismatch("last", exp_last[0], out_last);
                assert ({out_ingress_port, out_egress_port, out_prio, out_byte_length} == exp_meta[0])
                else report_mismatch("metadata", exp_meta[0],
                                     {out_ingress_port, out_egress_port, out_prio, out_byte_length});
                assert (out_drop_mark == exp_mark[0])
                else report_mismatch("drop mark", exp_mark[0], out_drop_mark);
                if (exp_last[0]) begin
                    exp_meta.pop_front();
                    exp_mark.pop_front();
                end
                exp_data.pop_front();
                exp_last.pop_front();
            end
        end
    end

    //////////////////////////////////////////////////
    // Stimulus tasks, all start and end on a falling edge
    //////////////////////////////////////////////////

    task automatic apply_reset();
        timer_reset = 1'b1;
        repeat (10) @(negedge core_clk_ifc);
        timer_reset = 1'b0;
        clear_model();
        assert (in_ready && !out_valid) else begin
            protocol_errors++;
            $display("Stream ports not idle after reset");
        end
    endtask

    task automatic write_config(input logic sel, input int port, input int value);
        cfg_valid = 1'b1;
        cfg_addr  = {sel, port[policer_pkg::port_w-1:0]};
        cfg_data  = value;
        @(negedge core_clk_ifc);
        cfg_valid = 1'b0;
    endtask

    task automatic send_packet(input int port, input int len, input logic mark);
        int   beats;
        int   egress;
        int   prio;
        logic rdy;
        egress = take_bits(4) % policer_pkg::num_ports;
        prio   = take_bits(policer_pkg::prio_w);
        beats  = (len + policer_pkg::data_bytes - 1) / policer_pkg::data_bytes;
        in_ingress_port = port[policer_pkg::port_w-1:0];
        in_egress_port  = egress[policer_pkg::port_w-1:0];
        in_prio         = prio[policer_pkg::prio_w-1:0];
        in_byte_length  = len[policer_pkg::byte_len_w-1:0];
        exp_meta.push_back({in_ingress_port, in_egress_port, in_prio, in_byte_length});
        exp_mark.push_back(mark);
        for (int b = 0; b < beats; b++) begin
            in_data  = {take_bits(32), take_bits(32)};
            in_last  = (b == beats - 1);
            in_valid = 1'b1;
            exp_data.push_back(in_data);
            exp_last.push_back(in_last);
            rdy = 1'b0;
            // Ready settles after the falling edge and holds until the rising one
            while (!rdy) begin
                #1;
                rdy = in_ready;
                @(negedge core_clk_ifc);
            end
        end
        in_valid = 1'b0;
    endtask

    task automatic send_random(input int count);
        int port;
        int len;
        repeat (count) begin
            port = take_bits(4) % policer_pkg::num_ports;
            len  = 64 + take_bits(11) % 1437;
            send_packet(port, len, police(port, len));
        end
    endtask

    task automatic drain_output();
        while (exp_data.size() != 0) begin
            @(negedge core_clk_ifc);
        end
    endtask

    task automatic wait_from(input longint t0, input int cycles);
        while (cycle_cnt - t0 < cycles) begin
            @(negedge core_clk_ifc);
        end
    endtask

    // Full burst, then a packet before 992 bytes drained, then one after a full drain
    task automatic run_cir_port(input int port);
        int     cir;
        int     early;
        int     late;
        longint t0;
        cir   = cir_min + take_bits(8);
        early = (992 * 256) / cir - 1;
        late  = (1000 * 256 + cir - 1) / cir + 4;
        write_config(policer_pkg::sel_cbs, port, 1000);
        write_config(policer_pkg::sel_cir, port, cir);
        t0 = cycle_cnt;
        send_packet(port, 1000, 1'b0);
        if (cycle_cnt - t0 > early) begin
            protocol_errors++;
            $display("CIR test could not keep its packet spacing");
        end
        wait_from(t0, early);
        // More than 8 bytes still in the bucket, so a full burst overflows
        send_packet(port, 1000, 1'b1);
        wait_from(t0, late);
        send_packet(port, 1000, 1'b0);
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        int bits;
        core_clk_ifc    = 1'b0;
        timer_reset     = 1'b1;
        enable          = '1;
        cfg_valid       = 1'b0;
        cfg_addr        = '0;
        cfg_data        = '0;
        in_valid        = 1'b0;
        in_data         = '0;
        in_last         = 1'b0;
        in_ingress_port = '0;
        in_egress_port  = '0;
        in_prio         = '0;
        in_byte_length  = '0;
        out_ready       = 1'b1;
        @(negedge core_clk_ifc);

        test_name = "zero_rate";
        apply_reset();
        send_random(12);
        drain_output();

        test_name = "max_rate";
        apply_reset();
        for (int p = 0; p < policer_pkg::num_ports; p++) begin
            write_config(policer_pkg::sel_cir, p, 32'h0000_FFFF);
            write_config(policer_pkg::sel_cbs, p, 32'h000F_FFFF);
            bucket_cbs[p] = 20'hF_FFFF;
        end
        send_random(12);
        drain_output();

        test_name = "random_cbs";
        apply_reset();
        for (int p = 0; p < policer_pkg::num_ports; p++) begin
            bits          = take_bits(13);
            bucket_cbs[p] = bits[policer_pkg::cbs_w-1:0];
            write_config(policer_pkg::sel_cbs, p, bits);
        end
        send_random(40);
        drain_output();

        test_name = "cir_drain";
        apply_reset();
        for (int p = 0; p < policer_pkg::num_ports; p++) begin
            run_cir_port(p);
        end
        drain_output();

        test_name = "random_enable";
        apply_reset();
        bits   = take_bits(policer_pkg::num_ports);
        enable = bits[policer_pkg::num_ports-1:0];
        send_random(24);
        drain_output();

        test_name = "output_gaps";
        apply_reset();
        bits    = take_bits(policer_pkg::num_ports);
        enable  = bits[policer_pkg::num_ports-1:0];
        gaps_on = 1'b1;
        send_random(30);
        drain_output();
        gaps_on = 1'b0;

        $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(watchdog_ns);
        $display("Watchdog expired with %0d beats still expected", exp_data.size());
        $display("** FAIL **");
        $finish;
    end

endmodule

// File: files.f
+incdir+dv
logic/policer_pkg.sv
logic/policer_lookup_if.sv
logic/policer_config_regs.sv
logic/token_bucket_bank.sv
logic/packet_marker.sv
logic/policer_top.sv
dv/policer_tb.sv

// File: logic/packet_marker.sv
/* Two-stage packet pipeline that looks up the ingress bucket on each first
   beat and carries the resulting drop mark on every beat of the packet. */

`timescale 1ns/1ps

module packet_marker (
    input  logic                                core_clk_ifc,
    input  logic                                timer_reset,

    input  logic                                in_valid,
    output logic                                in_ready,
    input  logic [policer_pkg::data_w-1:0]      in_data,
    input  logic                                in_last,
    input  logic [policer_pkg::port_w-1:0]      in_ingress_port,
    input  logic [policer_pkg::port_w-1:0]      in_egress_port,
    input  logic [policer_pkg::prio_w-1:0]      in_prio,
    input  logic [policer_pkg::byte_len_w-1:0]  in_byte_length,

    output logic                                out_valid,
    input  logic                                out_ready,
    output logic [policer_pkg::data_w-1:0]      out_data,
    output logic                                out_last,
    output logic [policer_pkg::port_w-1:0]      out_ingress_port,
    output logic [policer_pkg::port_w-1:0]      out_egress_port,
    output logic [policer_pkg::prio_w-1:0]      out_prio,
    output logic [policer_pkg::byte_len_w-1:0]  out_byte_length,
    output logic                                out_drop_mark,

    policer_lookup_if.marker                    lookup
);

    // Stage one holds the newest accepted beat
    logic                               s1_valid;
    logic [policer_pkg::data_w-1:0]     s1_data;
    logic                               s1_last;
    logic [policer_pkg::port_w-1:0]     s1_ingress_port;
    logic [policer_pkg::port_w-1:0]     s1_egress_port;
    logic [policer_pkg::prio_w-1:0]     s1_prio;
    logic [policer_pkg::byte_len_w-1:0] s1_byte_length;

    logic s1_ready;
    logic s2_ready;
    logic in_fire;
    logic sop;
    logic resp_pend;
    logic pkt_drop;
    logic s1_drop;

    //////////////////////////////////////////////////
    // Handshake and lookup request
    //////////////////////////////////////////////////

    assign s2_ready = !out_valid || out_ready;
    assign s1_ready = !s1_valid || s2_ready;
    assign in_ready = s1_ready;
    assign in_fire  = in_valid && in_ready;

    assign lookup.req_valid  = in_fire && sop;
    assign lookup.req_port   = in_ingress_port;
    assign lookup.req_length = in_byte_length;

    // Response arrives while the first beat sits in stage one
    assign s1_drop = resp_pend ? lookup.resp_drop : pkt_drop;

    //////////////////////////////////////////////////
    // Control state
    //////////////////////////////////////////////////

    always_ff @(posedge core_clk_ifc) begin
        if (timer_reset) begin
            sop       <= 1'b1;
            resp_pend <= 1'b0;
            pkt_drop  <= 1'b0;
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (in_fire) begin
                sop <= in_last;
            end
            resp_pend <= lookup.req_valid;
            if (resp_pend) begin
                pkt_drop <= lookup.resp_drop;
            end
            if (s1_ready) begin
                s1_valid <= in_valid;
            end
            if (s2_ready) begin
                out_valid <= s1_valid;
            end
        end
    end

    // Beat payload
    always_ff @(posedge core_clk_ifc) begin
        if (in_fire) begin
            s1_data         <= in_data;
            s1_last         <= in_last;
            s1_ingress_port <= in_ingress_port;
            s1_egress_port  <= in_egress_port;
            s1_prio         <= in_prio;
            s1_byte_length  <= in_byte_length;
        end
        if (s2_ready && s1_valid) begin
            out_data         <= s1_data;
            out_last         <= s1_last;
            out_ingress_port <= s1_ingress_port;
            out_egress_port  <= s1_egress_port;
            out_prio         <= s1_prio;
            out_byte_length  <= s1_byte_length;
            out_drop_mark    <= s1_drop;
        end
    end

endmodule

// File: logic/policer_config_regs.sv
/* CIR and CBS tables, loaded one entry per cycle from the config write port.
   A write shows up in the table outputs on the following cycle. */

`timescale 1ns/1ps

module policer_config_regs (
    input  logic                                                       core_clk_ifc,
    input  logic                                                       timer_reset,

    input  logic                                                       cfg_valid,
    input  logic [policer_pkg::cfg_addr_w-1:0]                         cfg_addr,
    input  logic [policer_pkg::cfg_data_w-1:0]                         cfg_data,

    output logic [policer_pkg::num_ports-1:0][policer_pkg::cir_w-1:0]  cir_table,
    output logic [policer_pkg::num_ports-1:0][policer_pkg::cbs_w-1:0]  cbs_table
);

    logic                           cfg_sel;
    logic [policer_pkg::port_w-1:0] cfg_port;
    logic                           cfg_hit;

    //////////////////////////////////////////////////
    // Address decode
    //////////////////////////////////////////////////

    assign cfg_sel  = cfg_addr[policer_pkg::cfg_addr_w-1];
    assign cfg_port = cfg_addr[policer_pkg::port_w-1:0];

    // Ports past the last policer are silently dropped
    assign cfg_hit  = cfg_valid && (cfg_port < policer_pkg::num_ports);

    //////////////////////////////////////////////////
    // Table update
    //////////////////////////////////////////////////

    always_ff @(posedge core_clk_ifc) begin
        if (timer_reset) begin
            cir_table <= '0;
            cbs_table <= '0;
        end else if (cfg_hit) begin
            case (cfg_sel)
                policer_pkg::sel_cir: begin
                    cir_table[cfg_port] <= cfg_data[policer_pkg::cir_w-1:0];
                end
                policer_pkg::sel_cbs: begin
                    cbs_table[cfg_port] <= cfg_data[policer_pkg::cbs_w-1:0];
                end
            endcase
        end
    end

endmodule

// File: logic/policer_lookup_if.sv
/* Bucket lookup path from the packet marker to the bucket bank.
   The response follows the request by exactly one cycle. */

`timescale 1ns/1ps

interface policer_lookup_if;

    logic                                 req_valid;
    logic [policer_pkg::port_w-1:0]       req_port;
    logic [policer_pkg::byte_len_w-1:0]   req_length;

    // Drop decision for the previous cycle's request
    logic                                 resp_drop;

    modport marker (
        output req_valid,
        output req_port,
        output req_length,
        input  resp_drop
    );

    modport bank (
        input  req_valid,
        input  req_port,
        input  req_length,
        output resp_drop
    );

endinterface

// File: logic/policer_pkg.sv
/* Shared widths, counts and config select codes for the ingress policer.
   Referenced by scoped name from every policer module. */

package policer_pkg;

    //////////////////////////////////////////////////
    // Port and packet geometry
    //////////////////////////////////////////////////

    // Ingress policers, one per physical port
    localparam int num_ports  = 11;
    localparam int port_w     = $clog2(num_ports);
    localparam int prio_w     = 3;

    // Enough for a 1500 byte MTU
    localparam int byte_len_w = 11;

    localparam int data_bytes = 8;
    localparam int data_w     = data_bytes * 8;

    //////////////////////////////////////////////////
    // Token bucket arithmetic
    //////////////////////////////////////////////////

    // CIR is bytes per cycle in fixed point
    localparam int cir_frac_w = 8;
    localparam int cir_w      = 16;

    // CBS in whole bytes
    localparam int cbs_w      = 20;

    // Level keeps the CIR fraction plus one guard bit above CBS
    localparam int level_w    = cbs_w + cir_frac_w + 1;

    //////////////////////////////////////////////////
    // Config write port
    //////////////////////////////////////////////////

    // Top address bit picks the table, low bits the port
    localparam int cfg_addr_w = 1 + port_w;
    localparam int cfg_data_w = 32;

    localparam logic sel_cir  = 1'b0;
    localparam logic sel_cbs  = 1'b1;

endpackage

// File: logic/policer_top.sv
/* Ingress token-bucket policer top level with plain config and stream ports.
   Marks packets that exceed their port's committed burst. */

`timescale 1ns/1ps

module policer_top (
    input  logic                                core_clk_ifc,
    input  logic                                timer_reset,

    // Policer enables and table writes
    input  logic [policer_pkg::num_ports-1:0]   enable,
    input  logic                                cfg_valid,
    input  logic [policer_pkg::cfg_addr_w-1:0]  cfg_addr,
    input  logic [policer_pkg::cfg_data_w-1:0]  cfg_data,

    input  logic                                in_valid,
    output logic                                in_ready,
    input  logic [policer_pkg::data_w-1:0]      in_data,
    input  logic                                in_last,
    input  logic [policer_pkg::port_w-1:0]      in_ingress_port,
    input  logic [policer_pkg::port_w-1:0]      in_egress_port,
    input  logic [policer_pkg::prio_w-1:0]      in_prio,
    input  logic [policer_pkg::byte_len_w-1:0]  in_byte_length,

    output logic                                out_valid,
    input  logic                                out_ready,
    output logic [policer_pkg::data_w-1:0]      out_data,
    output logic                                out_last,
    output logic [policer_pkg::port_w-1:0]      out_ingress_port,
    output logic [policer_pkg::port_w-1:0]      out_egress_port,
    output logic [policer_pkg::prio_w-1:0]      out_prio,
    output logic [policer_pkg::byte_len_w-1:0]  out_byte_length,
    output logic                                out_drop_mark
);

    logic [policer_pkg::num_ports-1:0][policer_pkg::cir_w-1:0] cir_table;
    logic [policer_pkg::num_ports-1:0][policer_pkg::cbs_w-1:0] cbs_table;

    policer_lookup_if lookup ();

    //////////////////////////////////////////////////
    // Config, buckets and stream marker
    //////////////////////////////////////////////////

    policer_config_regs u_config_regs (
        .core_clk_ifc (core_clk_ifc),
        .timer_reset  (timer_reset),
        .cfg_valid    (cfg_valid),
        .cfg_addr     (cfg_addr),
        .cfg_data     (cfg_data),
        .cir_table    (cir_table),
        .cbs_table    (cbs_table)
    );

    token_bucket_bank u_bucket_bank (
        .core_clk_ifc (core_clk_ifc),
        .timer_reset  (timer_reset),
        .enable       (enable),
        .cir_table    (cir_table),
        .cbs_table    (cbs_table),
        .lookup       (lookup)
    );

    packet_marker u_marker (
        .core_clk_ifc     (core_clk_ifc),
        .timer_reset      (timer_reset),
        .in_valid         (in_valid),
        .in_ready         (in_ready),
        .in_data          (in_data),
        .in_last          (in_last),
        .in_ingress_port  (in_ingress_port),
        .in_egress_port   (in_egress_port),
        .in_prio          (in_prio),
        .in_byte_length   (in_byte_length),
        .out_valid        (out_valid),
        .out_ready        (out_ready),
        .out_data         (out_data),
        .out_last         (out_last),
        .out_ingress_port (out_ingress_port),
        .out_egress_port  (out_egress_port),
        .out_prio         (out_prio),
        .out_byte_length  (out_byte_length),
        .out_drop_mark    (out_drop_mark),
        .lookup           (lookup)
    );

endmodule

// File: logic/token_bucket_bank.sv
/* Per-port token buckets in fixed point, drained by CIR every cycle.
   Answers one lookup per cycle with a registered drop decision. */

`timescale 1ns/1ps

module token_bucket_bank (
    input  logic                                                       core_clk_ifc,
    input  logic                                                       timer_reset,

    input  logic [policer_pkg::num_ports-1:0]                          enable,
    input  logic [policer_pkg::num_ports-1:0][policer_pkg::cir_w-1:0]  cir_table,
    input  logic [policer_pkg::num_ports-1:0][policer_pkg::cbs_w-1:0]  cbs_table,

    policer_lookup_if.bank                                             lookup
);

    localparam int whole_w = policer_pkg::level_w - policer_pkg::cir_frac_w;

    logic [policer_pkg::num_ports-1:0][policer_pkg::level_w-1:0] level_q;
    logic [policer_pkg::num_ports-1:0][policer_pkg::level_w-1:0] level_d;
    logic [policer_pkg::num_ports-1:0][policer_pkg::level_w-1:0] drained;

    logic [whole_w-1:0]              req_whole;
    logic [whole_w:0]                req_sum;
    logic [policer_pkg::level_w-1:0] len_fx;
    logic                            req_over;
    logic                            hit_drop;
    logic                            charge;

    //////////////////////////////////////////////////
    // Lookup decision
    //////////////////////////////////////////////////

    // Length moved up to the level's fixed-point scale
    assign len_fx = {{(policer_pkg::level_w - policer_pkg::byte_len_w
                       - policer_pkg::cir_frac_w){1'b0}},
                     lookup.req_length,
                     {policer_pkg::cir_frac_w{1'b0}}};

    always_comb begin
        req_whole = '0;
        req_sum   = '0;
        req_over  = 1'b0;
        hit_drop  = 1'b0;
        charge    = 1'b0;
        if (lookup.req_valid && (lookup.req_port < policer_pkg::num_ports)) begin
            // Compare against the level before this cycle's drain
            req_whole = level_q[lookup.req_port][policer_pkg::level_w-1:policer_pkg::cir_frac_w];
            req_sum   = req_whole + lookup.req_length;
            req_over  = req_sum > cbs_table[lookup.req_port];
            hit_drop  = enable[lookup.req_port] && req_over;
            // Disabled ports are never charged
            charge    = enable[lookup.req_port] && !req_over;
        end
    end

    //////////////////////////////////////////////////
    // Drain and charge
    //////////////////////////////////////////////////

    always_comb begin
        for (int p = 0; p < policer_pkg::num_ports; p++) begin
            // Saturate at empty
            if (level_q[p] > {{(policer_pkg::level_w - policer_pkg::cir_w){1'b0}}, cir_table[p]}) begin
                drained[p] = level_q[p] - cir_table[p];
            end else begin
                drained[p] = '0;
            end
            if (charge && (lookup.req_port == p)) begin
                level_d[p] = drained[p] + len_fx;
            end else begin
                level_d[p] = drained[p];
            end
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (timer_reset) begin
            level_q          <= '0;
            lookup.resp_drop <= 1'b0;
        end else begin
            level_q          <= level_d;
            lookup.resp_drop <= hit_drop;
        end
    end

endmodule
